// File: logic/exec_pkg.sv
/*
 * shared definitions for the execute stage: lane and warp sizes, the
 * operation encodings of each unit and the structs on dispatch, commit,
 * branch, warp-control and memory ports. Modules import it in their body
 */
`default_nettype none

package exec_pkg;

    localparam int num_threads_def = 4;
    localparam int num_warps       = 4;
    localparam int warp_bits       = $clog2(num_warps);
    localparam int xlen            = 32;
    localparam int mem_words       = 256;
    localparam int addr_bits       = $clog2(mem_words);

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_slt    = 4'd7,
        alu_beq    = 4'd8,
        alu_bne    = 4'd9,
        alu_ecall  = 4'd10,
        alu_ebreak = 4'd11
    } alu_op_e;

    typedef enum logic [3:0] {
        lsu_lw = 4'd0,
        lsu_sw = 4'd1
    } lsu_op_e;

    typedef enum logic [3:0] {
        sfu_csr_read  = 4'd0,
        sfu_csr_write = 4'd1,
        sfu_tmc       = 4'd2
    } sfu_op_e;

    // each unit reads the same four bits in its own way
    typedef union packed {
        alu_op_e alu;
        lsu_op_e lsu;
        sfu_op_e sfu;
    } exec_op_u;

    typedef enum logic [11:0] {
        csr_scratch   = 12'h340,
        csr_thread_id = 12'hcc0,
        csr_warp_id   = 12'hcc1,
        csr_core_id   = 12'hcc2
    } csr_addr_e;

    // a core may use fewer lanes than the default this struct is sized for
    typedef struct packed {
        logic [warp_bits-1:0]                  wid;
        logic [num_threads_def-1:0]            tmask;
        exec_op_u                              op;
        logic [xlen-1:0]                       pc;
        logic [xlen-1:0]                       imm;
        logic [4:0]                            rd;
        logic [num_threads_def-1:0][xlen-1:0]  rs1;
        logic [num_threads_def-1:0][xlen-1:0]  rs2;
    } dispatch_t;

    typedef struct packed {
        logic [warp_bits-1:0]                  wid;
        logic [num_threads_def-1:0]            tmask;
        logic [4:0]                            rd;
        logic                                  wb;
        logic [num_threads_def-1:0][xlen-1:0]  data;
    } commit_t;

    typedef struct packed {
        logic [warp_bits-1:0] wid;
        logic                 taken;
        logic [xlen-1:0]      target;
    } branch_ctl_t;

    typedef struct packed {
        logic [warp_bits-1:0]       wid;
        logic [num_threads_def-1:0] tmask;
    } warp_ctl_t;

    typedef struct packed {
        logic                 write;
        logic [addr_bits-1:0] addr;
        logic [xlen-1:0]      data;
    } mem_req_t;

endpackage

`default_nettype wire

// File: logic/alu_unit.sv
/*
 * integer ALU and branch resolution with one register stage. Results
 * leave through the commit port and branches pulse the branch port once
 */
`default_nettype none

module alu_unit #(
    parameter int NUM_THREADS = exec_pkg::num_threads_def
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   dispatch_valid,
    output logic                  dispatch_ready,
    input  wire exec_pkg::dispatch_t dispatch,
    output logic                  commit_valid,
    input  wire                   commit_ready,
    output exec_pkg::commit_t     commit,
    output logic                  branch_valid,
    output exec_pkg::branch_ctl_t branch,
    output logic                  sim_ebreak
);
    import exec_pkg::*;

    logic                                 dispatch_fire;
    logic                                 is_branch;
    logic                                 is_trap;
    logic                                 br_taken;
    logic [xlen-1:0]                      lead_rs1;
    logic [xlen-1:0]                      lead_rs2;
    logic [num_threads_def-1:0][xlen-1:0] result;

    // a new instruction may enter while the current result drains
    assign dispatch_ready = !commit_valid || commit_ready;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    assign is_branch = dispatch.op.alu inside {alu_beq, alu_bne};
    assign is_trap   = dispatch.op.alu inside {alu_ecall, alu_ebreak};

    // branch operands come from the lowest active lane
    always_comb begin
        lead_rs1 = '0;
        lead_rs2 = '0;
        for (int i = NUM_THREADS - 1; i >= 0; i--) begin
            if (dispatch.tmask[i]) begin
                lead_rs1 = dispatch.rs1[i];
                lead_rs2 = dispatch.rs2[i];
            end
        end
    end

    assign br_taken = (dispatch.op.alu == alu_beq) ? (lead_rs1 == lead_rs2)
                                                   : (lead_rs1 != lead_rs2);

    always_comb begin
        result = '0;
        for (int i = 0; i < NUM_THREADS; i++) begin
            if (dispatch.tmask[i]) begin
                case (dispatch.op.alu)
                    alu_add: result[i] = dispatch.rs1[i] + dispatch.rs2[i];
                    alu_sub: result[i] = dispatch.rs1[i] - dispatch.rs2[i];
                    alu_and: result[i] = dispatch.rs1[i] & dispatch.rs2[i];
                    alu_or:  result[i] = dispatch.rs1[i] | dispatch.rs2[i];
                    alu_xor: result[i] = dispatch.rs1[i] ^ dispatch.rs2[i];
                    alu_sll: result[i] = dispatch.rs1[i] << dispatch.rs2[i][4:0];
                    alu_srl: result[i] = dispatch.rs1[i] >> dispatch.rs2[i][4:0];
                    alu_slt: result[i] = xlen'($signed(dispatch.rs1[i])
                                               < $signed(dispatch.rs2[i]));
                    default: result[i] = '0;
                endcase
            end
        end
    end

    // the branch pulse lines up with the first cycle of its commit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            branch_valid <= dispatch_fire && is_branch;
            if (dispatch_fire) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            commit.wid    <= dispatch.wid;
            commit.tmask  <= dispatch.tmask;
            commit.rd     <= dispatch.rd;
            commit.wb     <= !(is_branch || is_trap);
            commit.data   <= result;
            branch.wid    <= dispatch.wid;
            branch.taken  <= br_taken;
            branch.target <= dispatch.pc + dispatch.imm;
        end
    end

    // warp 0 reaching a trap ends the program in simulation
    assign sim_ebreak = dispatch_fire && (dispatch.wid == '0) && is_trap;

    a_commit_stable: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit));

endmodule

`default_nettype wire

// File: logic/lsu_unit.sv
/*
 * load/store sequencer. Walks the active lanes lowest first with one memory
 * request per cycle, gathers load data and commits the whole warp
 */
`default_nettype none

module lsu_unit #(
    parameter int NUM_THREADS = exec_pkg::num_threads_def
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   dispatch_valid,
    output logic                  dispatch_ready,
    input  wire exec_pkg::dispatch_t dispatch,
    output logic                  commit_valid,
    input  wire                   commit_ready,
    output exec_pkg::commit_t     commit,
    output logic                  mem_req_valid,
    output exec_pkg::mem_req_t    mem_req,
    input  wire [exec_pkg::xlen-1:0] mem_rsp_data
);
    import exec_pkg::*;

    localparam int lane_bits = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain,
        st_commit
    } state_e;

    state_e                               state_q;
    dispatch_t                            req_q;
    logic [NUM_THREADS-1:0]               pend_q;
    logic [NUM_THREADS-1:0]               next_pend;
    logic [lane_bits-1:0]                 cur_lane;
    logic [lane_bits-1:0]                 rsp_lane_q;
    logic                                 rsp_load_q;
    logic [xlen-1:0]                      lane_addr;
    logic [num_threads_def-1:0][xlen-1:0] result_q;
    logic                                 dispatch_fire;

    // one instruction at a time from its handshake until its commit leaves
    assign dispatch_ready = (state_q == st_idle);
    assign dispatch_fire  = dispatch_valid && dispatch_ready;
    assign commit_valid   = (state_q == st_commit);
    assign mem_req_valid  = (state_q == st_issue);

    always_comb begin
        cur_lane = '0;
        for (int i = NUM_THREADS - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                cur_lane = lane_bits'(i);
            end
        end
    end

    assign next_pend = pend_q & ~(NUM_THREADS'(1) << cur_lane);

    // word index wraps at the memory size
    assign lane_addr     = req_q.rs1[cur_lane] + req_q.imm;
    assign mem_req.write = (req_q.op.lsu == lsu_sw);
    assign mem_req.addr  = lane_addr[addr_bits-1:0];
    assign mem_req.data  = req_q.rs2[cur_lane];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= st_idle;
            pend_q     <= '0;
            rsp_load_q <= 1'b0;
        end else begin
            rsp_load_q <= mem_req_valid && !mem_req.write;
            case (state_q)
                st_idle: begin
                    if (dispatch_fire) begin
                        pend_q  <= dispatch.tmask[NUM_THREADS-1:0];
                        state_q <= (|dispatch.tmask[NUM_THREADS-1:0]) ? st_issue : st_drain;
                    end
                end
                st_issue: begin
                    pend_q <= next_pend;
                    if (next_pend == '0) begin
                        state_q <= st_drain;
                    end
                end
                // last read data arrives here
                st_drain: state_q <= st_commit;
                st_commit: begin
                    if (commit_ready) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rsp_lane_q <= cur_lane;
        if (dispatch_fire) begin
            req_q    <= dispatch;
            result_q <= '0;
        end else if (rsp_load_q) begin
            result_q[rsp_lane_q] <= mem_rsp_data;
        end
    end

    assign commit.wid   = req_q.wid;
    assign commit.tmask = req_q.tmask;
    assign commit.rd    = req_q.rd;
    assign commit.wb    = (req_q.op.lsu == lsu_lw);
    assign commit.data  = result_q;

    // every request serves a lane that is still pending
    a_no_req_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> pend_q[cur_lane]);

endmodule

`default_nettype wire

// File: logic/local_mem.sv
/*
 * word-addressed data memory for the load/store unit. Accepts a request
 * every cycle and returns read data one cycle after the read
 */
`default_nettype none

module local_mem (
    input  wire                      clk,
    input  wire                      mem_req_valid,
    input  wire exec_pkg::mem_req_t  mem_req,
    output logic [exec_pkg::xlen-1:0] mem_rsp_data
);
    import exec_pkg::*;

    logic [xlen-1:0] mem [0:mem_words-1];

    always_ff @(posedge clk) begin
        if (mem_req_valid) begin
            if (mem_req.write) begin
                mem[mem_req.addr] <= mem_req.data;
            end else begin
                mem_rsp_data <= mem[mem_req.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/sfu_unit.sv
/*
 * special-function unit. Serves control-register reads, the scratch
 * register write and thread-mask changes, with one cycle of latency
 */
`default_nettype none

module sfu_unit #(
    parameter int CORE_ID     = 0,
    parameter int NUM_THREADS = exec_pkg::num_threads_def
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   dispatch_valid,
    output logic                  dispatch_ready,
    input  wire exec_pkg::dispatch_t dispatch,
    output logic                  commit_valid,
    input  wire                   commit_ready,
    output exec_pkg::commit_t     commit,
    output logic                  warp_ctl_valid,
    output exec_pkg::warp_ctl_t   warp_ctl
);
    import exec_pkg::*;

    logic                                 dispatch_fire;
    logic                                 is_tmc;
    logic [xlen-1:0]                      scratch_q;
    logic [xlen-1:0]                      lead_rs1;
    logic [num_threads_def-1:0][xlen-1:0] result;
    csr_addr_e                            csr_addr;

    assign dispatch_ready = !commit_valid || commit_ready;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;
    assign is_tmc         = (dispatch.op.sfu == sfu_tmc);
    assign csr_addr       = csr_addr_e'(dispatch.imm[11:0]);

    always_comb begin
        lead_rs1 = '0;
        for (int i = NUM_THREADS - 1; i >= 0; i--) begin
            if (dispatch.tmask[i]) begin
                lead_rs1 = dispatch.rs1[i];
            end
        end
    end

    // a write hands back the old scratch value on every active lane
    always_comb begin
        result = '0;
        for (int i = 0; i < NUM_THREADS; i++) begin
            if (dispatch.tmask[i]) begin
                if (dispatch.op.sfu == sfu_csr_write) begin
                    result[i] = scratch_q;
                end else if (dispatch.op.sfu == sfu_csr_read) begin
                    case (csr_addr)
                        csr_thread_id: result[i] = xlen'(i);
                        csr_warp_id:   result[i] = xlen'(dispatch.wid);
                        csr_core_id:   result[i] = xlen'(CORE_ID);
                        csr_scratch:   result[i] = scratch_q;
                        default:       result[i] = '0;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid   <= 1'b0;
            warp_ctl_valid <= 1'b0;
            scratch_q      <= '0;
        end else begin
            warp_ctl_valid <= dispatch_fire && is_tmc;
            if (dispatch_fire && (dispatch.op.sfu == sfu_csr_write)) begin
                scratch_q <= lead_rs1;
            end
            if (dispatch_fire) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            commit.wid     <= dispatch.wid;
            commit.tmask   <= dispatch.tmask;
            commit.rd      <= dispatch.rd;
            commit.wb      <= !is_tmc;
            commit.data    <= result;
            warp_ctl.wid   <= dispatch.wid;
            // new mask sits in the low bits of lane 0
            warp_ctl.tmask <= dispatch.rs1[0][num_threads_def-1:0];
        end
    end

    a_tmc_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        dispatch_fire && is_tmc |=> warp_ctl_valid && (warp_ctl.tmask != '0));

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
/*
 * execute stage of the SIMT core. Routes the three dispatch ports to the
 * ALU, load/store and special-function units and exposes their commits
 */
`default_nettype none

module exec_stage #(
    parameter int CORE_ID     = 0,
    parameter int NUM_THREADS = exec_pkg::num_threads_def
) (
    input  wire                   clk,
    input  wire                   arst_n,

    input  wire                   alu_dispatch_valid,
    output logic                  alu_dispatch_ready,
    input  wire exec_pkg::dispatch_t alu_dispatch,
    input  wire                   lsu_dispatch_valid,
    output logic                  lsu_dispatch_ready,
    input  wire exec_pkg::dispatch_t lsu_dispatch,
    input  wire                   sfu_dispatch_valid,
    output logic                  sfu_dispatch_ready,
    input  wire exec_pkg::dispatch_t sfu_dispatch,

    output logic                  alu_commit_valid,
    input  wire                   alu_commit_ready,
    output exec_pkg::commit_t     alu_commit,
    output logic                  lsu_commit_valid,
    input  wire                   lsu_commit_ready,
    output exec_pkg::commit_t     lsu_commit,
    output logic                  sfu_commit_valid,
    input  wire                   sfu_commit_ready,
    output exec_pkg::commit_t     sfu_commit,

    output logic                  branch_valid,
    output exec_pkg::branch_ctl_t branch,
    output logic                  warp_ctl_valid,
    output exec_pkg::warp_ctl_t   warp_ctl,

    // raised for warp 0 traps so simulation can stop
    output logic                  sim_ebreak
);
    import exec_pkg::*;

    logic            mem_req_valid;
    mem_req_t        mem_req;
    logic [xlen-1:0] mem_rsp_data;

    alu_unit #(
        .NUM_THREADS (NUM_THREADS)
    ) i_alu_unit (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (alu_dispatch_valid),
        .dispatch_ready (alu_dispatch_ready),
        .dispatch       (alu_dispatch),
        .commit_valid   (alu_commit_valid),
        .commit_ready   (alu_commit_ready),
        .commit         (alu_commit),
        .branch_valid   (branch_valid),
        .branch         (branch),
        .sim_ebreak     (sim_ebreak)
    );

    lsu_unit #(
        .NUM_THREADS (NUM_THREADS)
    ) i_lsu_unit (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (lsu_dispatch_valid),
        .dispatch_ready (lsu_dispatch_ready),
        .dispatch       (lsu_dispatch),
        .commit_valid   (lsu_commit_valid),
        .commit_ready   (lsu_commit_ready),
        .commit         (lsu_commit),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_rsp_data   (mem_rsp_data)
    );

    local_mem i_local_mem (
        .clk           (clk),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_data  (mem_rsp_data)
    );

    sfu_unit #(
        .CORE_ID     (CORE_ID),
        .NUM_THREADS (NUM_THREADS)
    ) i_sfu_unit (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (sfu_dispatch_valid),
        .dispatch_ready (sfu_dispatch_ready),
        .dispatch       (sfu_dispatch),
        .commit_valid   (sfu_commit_valid),
        .commit_ready   (sfu_commit_ready),
        .commit         (sfu_commit),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl)
    );

endmodule

`default_nettype wire

// File: bench/exec_stage_tb.sv
/*
 * testbench for the execute stage. Reads instructions from the stimulus
 * file, feeds each unit's dispatch port in file order, throttles the
 * commit ports at random and checks commits, branch and warp-control
 * pulses and the trap flag against the expected columns
 */
`default_nettype none

module exec_stage_tb;
    import exec_pkg::*;

    localparam int unit_alu = 0;
    localparam int unit_sfu = 2;
    localparam int core_id  = 3;

    // one stimulus line with the dispatch fields and what should come back
    typedef struct packed {
        logic [1:0]                           unit;
        dispatch_t                            d;
        logic [num_threads_def-1:0][xlen-1:0] exp_data;
        logic                                 exp_wb;
        logic [xlen-1:0]                      ctl;
    } stim_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        disp_valid [3];
    logic        disp_ready [3];
    dispatch_t   disp [3];
    logic        commit_valid [3];
    logic        commit_ready [3];
    commit_t     commits [3];
    logic        branch_valid;
    branch_ctl_t br;
    logic        warp_ctl_valid;
    warp_ctl_t   wctl;
    logic        sim_ebreak;

    stim_t  stim [$];
    // stimulus indices dispatched and not yet committed with the oldest first
    int     inflight [$];
    int     br_exp [$];
    int     wc_exp [$];
    int     cur_idx [3];
    string  unit_names [3] = '{"alu", "lsu", "sfu"};
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit = 1000;
    integer seed = 32'hc2ed3741;

    exec_stage #(
        .CORE_ID     (core_id),
        .NUM_THREADS (num_threads_def)
    ) i_dut (
        .clk                (clk),
        .arst_n             (arst_n),
        .alu_dispatch_valid (disp_valid[0]),
        .alu_dispatch_ready (disp_ready[0]),
        .alu_dispatch       (disp[0]),
        .lsu_dispatch_valid (disp_valid[1]),
        .lsu_dispatch_ready (disp_ready[1]),
        .lsu_dispatch       (disp[1]),
        .sfu_dispatch_valid (disp_valid[2]),
        .sfu_dispatch_ready (disp_ready[2]),
        .sfu_dispatch       (disp[2]),
        .alu_commit_valid   (commit_valid[0]),
        .alu_commit_ready   (commit_ready[0]),
        .alu_commit         (commits[0]),
        .lsu_commit_valid   (commit_valid[1]),
        .lsu_commit_ready   (commit_ready[1]),
        .lsu_commit         (commits[1]),
        .sfu_commit_valid   (commit_valid[2]),
        .sfu_commit_ready   (commit_ready[2]),
        .sfu_commit         (commits[2]),
        .branch_valid       (branch_valid),
        .branch             (br),
        .warp_ctl_valid     (warp_ctl_valid),
        .warp_ctl           (wctl),
        .sim_ebreak         (sim_ebreak)
    );

    always #10 clk = ~clk;

    task automatic compare_word(input string sig, input logic [xlen-1:0] exp,
                                input logic [xlen-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, actual %h", $time, sig, exp, got);
        end
    endtask

    task automatic check_commit(input string name, input stim_t e, input commit_t c);
        compare_word({name, ".wid"}, 32'(e.d.wid), 32'(c.wid));
        compare_word({name, ".tmask"}, 32'(e.d.tmask), 32'(c.tmask));
        compare_word({name, ".rd"}, 32'(e.d.rd), 32'(c.rd));
        compare_word({name, ".wb"}, 32'(e.exp_wb), 32'(c.wb));
        for (int i = 0; i < num_threads_def; i++) begin
            compare_word($sformatf("%s.data[%0d]", name, i), e.exp_data[i], c.data[i]);
        end
    endtask

    // units commit in their own order, so take the oldest entry of that unit
    task automatic retire(input int u, input commit_t c);
        int j;
        j = 0;
        while (j < inflight.size() && int'(stim[inflight[j]].unit) != u) begin
            j++;
        end
        if (j == inflight.size()) begin
            errors++;
            $display("%s committed at %0t with nothing dispatched", unit_names[u], $time);
        end else begin
            check_commit({unit_names[u], "_commit"}, stim[inflight[j]], c);
            inflight.delete(j);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        stim_t       s;
        logic [31:0] col [0:20];
        fd = $fopen("bench/exec_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file bench/exec_stimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                        col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                        col[14], col[15], col[16], col[17], col[18], col[19], col[20]);
            if (n != 21 || col[0] > 2) begin
                errors++;
                $display("malformed stimulus line skipped: %s", line);
                continue;
            end
            s = '0;
            s.unit       = col[0][1:0];
            s.d.op.alu   = alu_op_e'(col[1][3:0]);
            s.d.wid      = col[2][warp_bits-1:0];
            s.d.tmask    = col[3][num_threads_def-1:0];
            s.d.pc       = col[4];
            s.d.imm      = col[5];
            s.d.rd       = col[6][4:0];
            for (int i = 0; i < num_threads_def; i++) begin
                s.d.rs1[i]     = col[7 + i];
                s.d.rs2[i]     = col[11 + i];
                s.exp_data[i]  = col[15 + i];
            end
            s.exp_wb = col[19][0];
            s.ctl    = col[20];
            stim.push_back(s);
        end
        $fclose(fd);
    endtask

    // holds each instruction on the port until the unit takes it
    task automatic drive_unit(input int u);
        for (int k = 0; k < stim.size(); k++) begin
            if (int'(stim[k].unit) == u) begin
                disp_valid[u] <= 1'b1;
                disp[u]       <= stim[k].d;
                cur_idx[u]    <= k;
                @(posedge clk);
                while (!disp_ready[u]) begin
                    @(posedge clk);
                end
            end
        end
        disp_valid[u] <= 1'b0;
    endtask

    always @(posedge clk) begin
        stim_t e;
        logic  exp_trap;
        if (arst_n) begin
            for (int u = 0; u < 3; u++) begin
                if (commit_valid[u] && commit_ready[u]) begin
                    retire(u, commits[u]);
                end
            end

            if (branch_valid) begin
                if (br_exp.size() == 0) begin
                    errors++;
                    $display("branch pulse at %0t without a branch in flight", $time);
                end else begin
                    e = stim[br_exp.pop_front()];
                    compare_word("branch.wid", 32'(e.d.wid), 32'(br.wid));
                    compare_word("branch.taken", 32'(e.ctl[0]), 32'(br.taken));
                    compare_word("branch.target", e.d.pc + e.d.imm, br.target);
                end
            end

            if (warp_ctl_valid) begin
                if (wc_exp.size() == 0) begin
                    errors++;
                    $display("warp-control pulse at %0t without a tmc in flight", $time);
                end else begin
                    e = stim[wc_exp.pop_front()];
                    compare_word("warp_ctl.wid", 32'(e.d.wid), 32'(wctl.wid));
                    compare_word("warp_ctl.tmask", 32'(e.ctl[num_threads_def-1:0]),
                                 32'(wctl.tmask));
                end
            end

            // the stop flag belongs to the ALU handshake on this very edge
            exp_trap = 1'b0;
            if (disp_valid[unit_alu] && disp_ready[unit_alu]) begin
                e = stim[cur_idx[unit_alu]];
                if (e.d.op.alu inside {alu_ecall, alu_ebreak}) begin
                    exp_trap = e.ctl[0];
                end
            end
            compare_word("sim_ebreak", 32'(exp_trap), 32'(sim_ebreak));

            for (int u = 0; u < 3; u++) begin
                if (disp_valid[u] && disp_ready[u]) begin
                    e = stim[cur_idx[u]];
                    inflight.push_back(cur_idx[u]);
                    if (u == unit_alu && (e.d.op.alu inside {alu_beq, alu_bne})) begin
                        br_exp.push_back(cur_idx[u]);
                    end
                    if (u == unit_sfu && e.d.op.sfu == sfu_tmc) begin
                        wc_exp.push_back(cur_idx[u]);
                    end
                end
            end
        end
        // roughly one stalled cycle in four on each commit port
        for (int u = 0; u < 3; u++) begin
            commit_ready[u] <= ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles with %0d instructions still in flight, %0d errors",
                     cycles, inflight.size(), errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        arst_n = 1'b0;
        for (int u = 0; u < 3; u++) begin
            disp_valid[u]   = 1'b0;
            disp[u]         = '0;
            commit_ready[u] = 1'b0;
            cur_idx[u]      = 0;
        end
        load_stimulus();
        if (stim.size() == 0) begin
            errors++;
            $display("no stimulus lines were read");
        end else begin
            limit = 40 * stim.size();
        end

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        fork
            drive_unit(0);
            drive_unit(1);
            drive_unit(2);
        join

        @(posedge clk);
        while (inflight.size() != 0) begin
            @(posedge clk);
        end
        // a few idle cycles to catch late or repeated pulses
        repeat (6) @(posedge clk);

        if (br_exp.size() != 0) begin
            errors++;
            $display("%0d branch instructions never pulsed the branch port", br_exp.size());
        end
        if (wc_exp.size() != 0) begin
            errors++;
            $display("%0d tmc instructions never pulsed warp control", wc_exp.size());
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/exec_pkg.sv
logic/alu_unit.sv
logic/lsu_unit.sv
logic/local_mem.sv
logic/sfu_unit.sv
logic/exec_stage.sv
bench/exec_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the execute stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module exec_stage_tb \
    -f files.f -o exec_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exec_stage_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASSED" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

// File: bench/exec_stimulus.txt
# unit op warp mask pc imm rd rs1[0..3] rs2[0..3] exp[0..3] wb ctl, all hex
# unit 0 alu 1 lsu 2 sfu, ctl is branch taken, trap stop flag or new thread mask
0 0 0 f 100 0 5 1 2 3 4 10 20 30 40 11 22 33 44 1 0
0 1 1 5 104 0 6 50 60 70 80 8 8 8 8 48 0 68 0 1 0
0 5 2 f 108 0 7 1 3 80000000 f 4 1f 1 0 10 80000000 0 f 1 0
0 7 3 f 10c 0 8 ffffffff 5 5 80000000 1 5 6 7fffffff 1 0 1 1 1 0
0 6 3 f 110 0 9 80000000 f0 ffffffff 1 1f 4 1c 1 1 f f 0 1 0
0 4 0 f 114 0 a ff00 0f0f aaaa 1234 00ff 0f0f 5555 1234 ffff 0 ffff 0 1 0
0 8 1 6 200 40 0 0 7 9 0 0 7 8 0 0 0 0 0 0 1
0 9 2 8 300 fffffff0 0 0 0 0 c 0 0 0 c 0 0 0 0 0 0
0 a 0 1 400 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
0 a 1 1 404 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 0 f 500 10 0 0 1 2 3 a0 a1 a2 a3 0 0 0 0 0 0
1 1 1 5 504 20 0 0 1 2 3 b0 b1 b2 b3 0 0 0 0 0 0
1 1 2 2 508 1 0 0 ff 0 0 0 c1 0 0 0 0 0 0 0 0
1 0 0 f 50c 10 b 3 2 1 0 0 0 0 0 a3 a2 a1 a0 1 0
1 0 1 5 510 20 c 0 5 2 7 0 0 0 0 b0 0 b2 0 1 0
1 0 2 2 514 0 d 0 100 0 0 0 0 0 0 0 c1 0 0 1 0
2 0 0 f 600 cc0 e 0 0 0 0 0 0 0 0 0 1 2 3 1 0
2 0 2 b 604 cc1 f 0 0 0 0 0 0 0 0 2 2 0 2 1 0
2 0 1 f 608 cc2 10 0 0 0 0 0 0 0 0 3 3 3 3 1 0
2 1 0 f 60c 340 11 1234 0 0 0 0 0 0 0 0 0 0 0 1 0
2 1 3 6 610 340 12 0 beef 55 0 0 0 0 0 0 1234 1234 0 1 0
2 0 3 f 614 340 13 0 0 0 0 0 0 0 0 beef beef beef beef 1 0
2 2 1 f 618 0 0 5 0 0 0 0 0 0 0 0 0 0 0 0 5
